// File: sim.f
rtl/cpu_pkg.sv
rtl/stage_info_if.sv
rtl/execute_pipeline_unit.sv
rtl/stage_shadow_chain.sv
rtl/execute_unit.sv
rtl/execute_subsystem.sv
testbench/tb_execute_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execute subsystem testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module tb_execute_subsystem -f sim.f; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_execute_subsystem 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1

// File: testbench/tb_execute_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_execute_subsystem;
    import cpu_pkg::*;

    localparam int num_cycles   = 2000;
    localparam int reset_cycles = 4;
    localparam int cycle_limit  = num_cycles + reset_cycles + 100;  // plus margin

    logic        clk;
    logic        rst_n;
    logic [31:0] instr_in;
    logic        branch_in;
    opcode_t     opcode;
    reg_idx_t    rn;
    reg_idx_t    rs;
    reg_idx_t    rm;
    logic [4:0]  imm5;
    logic        branch_value;
    logic [31:0] instr_output;
    fwd_sel_t    sel_a_in;
    fwd_sel_t    sel_b_in;
    fwd_sel_t    sel_shift_in;
    logic        sel_shift;
    logic        en_a;
    logic        en_b;
    logic        en_s;
    logic        stall_pc;

    // reference model of the execute slot and the three shadow words
    logic [31:0] ex_q;
    logic        br_q;
    logic [31:0] shadow [3];    // memory, wait, writeback
    fwd_sel_t    exp_sel [3];   // rn, rm, rs sources
    logic [2:0]  exp_en;        // en_a, en_b, en_s
    logic        exp_shift;
    logic        exp_stall;
    int          cycles = 0;

    execute_subsystem execute_subsystem_inst (.*);

    always #2 clk = ~clk;  // 4 ns period

    // guard against a stuck run
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit)
            report_failure($sformatf("run did not finish within %0d cycles", cycle_limit));
    end

    function automatic opcode_t op_of(input logic [31:0] word);
        return (word == instr_nop) ? opcode_nop : word[26:20];
    endfunction
    function automatic logic reads_rn(input opcode_t op);
        return op != opcode_nop && ((!op[6] && op[3:0] != 4'd0) || op[6:5] == 2'b11);
    endfunction
    function automatic logic reads_rm(input opcode_t op);
        return (!op[6] && op[4]) || (op[6:5] == 2'b11 && op[3])
            || (op[6:2] == 5'b10010 && op[0]);
    endfunction
    function automatic logic reads_rs(input opcode_t op);
        return op[6:4] == 3'b011;
    endfunction
    function automatic logic loads_data(input opcode_t op);
        return op[6:4] == 3'b110 || op[6:3] == 4'b1000;  // ldr, ldr literal
    endfunction
    function automatic logic accesses_mem(input opcode_t op);
        return op[6:5] == 2'b11 || loads_data(op);
    endfunction

    // expected controls for the current model state
    task automatic compute_expected();
        opcode_t    op;
        opcode_t    mop;
        reg_idx_t   src [3];
        logic [2:0] used;
        op   = op_of(ex_q);
        mop  = op_of(shadow[0]);
        src  = '{ex_q[19:16], ex_q[3:0], ex_q[11:8]};
        used = {reads_rs(op), reads_rm(op), reads_rn(op)};
        exp_stall = 1'b0;
        for (int i = 0; i < 3; i++) begin
            if (!used[i])
                exp_sel[i] = 2'b00;
            else if (mop != opcode_nop && ((accesses_mem(mop) && shadow[0][21]
                    && shadow[0][19:16] == src[i]) || (!mop[6] && shadow[0][15:12] == src[i])))
                exp_sel[i] = 2'b01;   // alu result or pre-indexed base
            else if (loads_data(op_of(shadow[2])) && shadow[2][15:12] == src[i])
                exp_sel[i] = 2'b10;
            else
                exp_sel[i] = 2'b00;
            if (used[i] && ((loads_data(mop) && shadow[0][15:12] == src[i])
                    || (loads_data(op_of(shadow[1])) && shadow[1][15:12] == src[i])))
                exp_stall = 1'b1;     // load data still in flight
        end
        exp_en    = 3'b000;
        exp_shift = 1'b0;
        if (!op[6] && op[5:4] != 2'b10 && ex_q[31:28] != 4'hf) begin
            exp_en    = {op[3], op[4], op[4]};
            exp_shift = op[4] && op[5];
        end else if (accesses_mem(op)) begin
            exp_en = op[3] ? 3'b111 : 3'b100;
            if (op[6:3] == 4'b1000)
                exp_sel[0] = 2'b11;   // literal load reads pc
        end else if (op[6:3] == 4'b1001) begin
            exp_en     = {1'b0, op[0], 1'b1};
            exp_shift  = 1'b1;
            exp_sel[2] = 2'b11;
            if (!op[0])
                exp_sel[0] = 2'b11;
        end
    endtask

    task automatic update_model();
        shadow[2] = shadow[1];
        shadow[1] = shadow[0];
        shadow[0] = exp_stall ? instr_nop : ex_q;   // bubble per stalled cycle
        if (!exp_stall) begin
            ex_q = branch_in ? instr_nop : instr_in;
            br_q = branch_in;
        end
    endtask

    // register fields kept to r0..r3 so hazards show up often
    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w        = $urandom;
        w[19:16] = 4'($urandom_range(3, 0));
        w[15:12] = 4'($urandom_range(3, 0));
        w[11:8]  = 4'($urandom_range(3, 0));
        w[3:0]   = 4'($urandom_range(3, 0));
        if ($urandom_range(7, 0) == 0)
            w[26:20] = $urandom_range(1, 0) ? {3'b110, 4'($urandom_range(15, 0))}
                                            : {4'b1000, 3'($urandom_range(7, 0))};
        return w;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first failure");
    endtask
    task automatic check_opcode(input string name, input opcode_t exp, input opcode_t act);
        if (act !== exp)
            report_failure($sformatf("** Error %s expected %b actual %b", name, exp, act));
    endtask
    task automatic check_sel(input string name, input fwd_sel_t exp, input fwd_sel_t act);
        if (act !== exp)
            report_failure($sformatf("** Error %s expected %b actual %b", name, exp, act));
    endtask
    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_failure($sformatf("** Error %s expected %b actual %b", name, exp, act));
    endtask
    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
            report_failure($sformatf("** Error %s expected %h actual %h", name, exp, act));
    endtask

    initial begin
        int unsigned seed_ret;
        logic        held;      // previous cycle was stalled
        logic        squashed;  // previous cycle took a branch
        opcode_t     last_op;
        string       tag;
        seed_ret  = $urandom(32'h3c733782);
        clk       = 1'b0;
        rst_n     = 1'b0;
        instr_in  = instr_nop;
        branch_in = 1'b0;
        ex_q      = instr_nop;
        br_q      = 1'b0;
        shadow    = '{default: instr_nop};
        held      = 1'b0;
        squashed  = 1'b0;
        last_op   = opcode_nop;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_bit("reset stall_pc", 1'b0, stall_pc);
        check_bit("reset en_a", 1'b0, en_a);
        check_bit("reset en_b", 1'b0, en_b);
        check_bit("reset en_s", 1'b0, en_s);
        check_bit("reset sel_shift", 1'b0, sel_shift);
        check_sel("reset sel_a_in", 2'b00, sel_a_in);
        check_sel("reset sel_b_in", 2'b00, sel_b_in);
        check_sel("reset sel_shift_in", 2'b00, sel_shift_in);
        check_word("reset instr_output", instr_nop, instr_output);
        compute_expected();
        for (int cyc = 0; cyc < num_cycles; cyc++) begin
            @(posedge clk);
            update_model();
            @(negedge clk);
            compute_expected();
            if (!exp_stall) begin   // inputs held through a stall
                instr_in  = random_word();
                branch_in = $urandom_range(15, 0) == 0;
            end
            #1;                     // sample well before the next rising edge
            tag = $sformatf("cycle %0d", cyc);
            check_opcode({tag, " opcode"}, op_of(ex_q), opcode);
            check_word({tag, " fields"}, {15'd0, ex_q[19:16], ex_q[11:8], ex_q[3:0], ex_q[11:7]},
                {15'd0, rn, rs, rm, imm5});
            check_word({tag, " instr_output"}, exp_stall ? instr_nop : ex_q, instr_output);
            check_bit({tag, " branch_value"}, br_q, branch_value);
            check_bit({tag, " stall_pc"}, exp_stall, stall_pc);
            check_sel({tag, " sel_a_in"}, exp_sel[0], sel_a_in);
            check_sel({tag, " sel_b_in"}, exp_sel[1], sel_b_in);
            check_sel({tag, " sel_shift_in"}, exp_sel[2], sel_shift_in);
            check_bit({tag, " sel_shift"}, exp_shift, sel_shift);
            check_bit({tag, " en_a"}, exp_en[2], en_a);
            check_bit({tag, " en_b"}, exp_en[1], en_b);
            check_bit({tag, " en_s"}, exp_en[0], en_s);
            if (held)
                check_opcode({tag, " stall hold"}, last_op, opcode);
            if (squashed) begin
                check_opcode({tag, " squash opcode"}, opcode_nop, opcode);
                check_bit({tag, " squash branch_value"}, 1'b1, branch_value);
            end
            held     = exp_stall;
            squashed = branch_in && !exp_stall;
            last_op  = op_of(ex_q);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/execute_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module execute_subsystem (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [31:0]       instr_in,
    input  logic              branch_in,
    output cpu_pkg::opcode_t  opcode,
    output cpu_pkg::reg_idx_t rn,
    output cpu_pkg::reg_idx_t rs,
    output cpu_pkg::reg_idx_t rm,
    output logic [4:0]        imm5,
    output logic              branch_value,
    output logic [31:0]       instr_output,
    output cpu_pkg::fwd_sel_t sel_a_in,
    output cpu_pkg::fwd_sel_t sel_b_in,
    output cpu_pkg::fwd_sel_t sel_shift_in,
    output logic              sel_shift,
    output logic              en_a,
    output logic              en_b,
    output logic              en_s,
    output logic              stall_pc
);
    localparam int shadow_depth = 3;  // memory, wait, writeback

    stage_info_if info ();   // downstream stage view for the controller

    execute_unit execute_unit_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_in     (instr_in),
        .branch_in    (branch_in),
        .info         (info.consumer),
        .opcode       (opcode),
        .rn           (rn),
        .rs           (rs),
        .rm           (rm),
        .imm5         (imm5),
        .branch_value (branch_value),
        .instr_output (instr_output),   // also feeds the shadow chain
        .sel_a_in     (sel_a_in),
        .sel_b_in     (sel_b_in),
        .sel_shift_in (sel_shift_in),
        .sel_shift    (sel_shift),
        .en_a         (en_a),
        .en_b         (en_b),
        .en_s         (en_s),
        .stall_pc     (stall_pc)
    );

    stage_shadow_chain #(
        .shadow_depth (shadow_depth)
    ) stage_shadow_chain_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_output (instr_output),
        .info         (info.producer)
    );

endmodule

`default_nettype wire

// File: rtl/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [31:0]         instr_in,
    input  logic                branch_in,
    stage_info_if.consumer      info,
    output cpu_pkg::opcode_t    opcode,
    output cpu_pkg::reg_idx_t   rn,
    output cpu_pkg::reg_idx_t   rs,
    output cpu_pkg::reg_idx_t   rm,
    output logic [4:0]          imm5,
    output logic                branch_value,
    output logic [31:0]         instr_output,
    output cpu_pkg::fwd_sel_t   sel_a_in,
    output cpu_pkg::fwd_sel_t   sel_b_in,
    output cpu_pkg::fwd_sel_t   sel_shift_in,
    output logic                sel_shift,
    output logic                en_a,
    output logic                en_b,
    output logic                en_s,
    output logic                stall_pc
);
    import cpu_pkg::*;

    cond_t       cond;
    logic [31:0] instr_exe;   // raw execute slot

    // source operand slots in the order rn rm rs
    reg_idx_t    src_reg [3];
    fwd_sel_t    fwd [3];
    logic [2:0]  used;
    logic [2:0]  alu_hit;
    logic [2:0]  load_hit;
    logic [2:0]  hazard;

    // downstream stage qualifiers
    logic mem_live;
    logic mem_wr_rd;
    logic mem_base_wb;
    logic mem_ld;
    logic wait_ld;
    logic wb_ld;
    logic ldr_lit;

    execute_pipeline_unit execute_pipeline_unit_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_in     (instr_in),
        .branch_in    (branch_in),
        .sel_stall    (stall_pc),
        .cond         (cond),
        .opcode       (opcode),
        .rn           (rn),
        .rs           (rs),
        .rm           (rm),
        .imm5         (imm5),
        .branch_value (branch_value),
        .instr_output (instr_exe)
    );

    assign mem_live    = info.opcode_memory != opcode_nop;
    assign mem_wr_rd   = writes_rd(info.opcode_memory);
    assign mem_base_wb = info.sel_w_addr1_memory == wsel_pre;
    assign mem_ld      = is_load(info.opcode_memory);      // result not ready yet
    assign wait_ld     = is_load(info.opcode_memory_wait);
    assign wb_ld       = info.opcode_writeback != opcode_nop && is_load(info.opcode_writeback);
    assign ldr_lit     = opcode[6:3] == 4'b1000;

    assign src_reg[0] = rn;
    assign src_reg[1] = rm;
    assign src_reg[2] = rs;
    assign used[0]    = uses_rn(opcode);
    assign used[1]    = uses_rm(opcode);
    assign used[2]    = uses_rs(opcode);

    for (genvar i = 0; i < 3; i++) begin : g_src
        // memory stage wins since it holds the younger result
        assign alu_hit[i] = mem_live
            && ((mem_base_wb && info.rn_memory == src_reg[i])
                || (mem_wr_rd && info.rd_memory == src_reg[i]));
        assign load_hit[i] = wb_ld && info.rt_writeback == src_reg[i];
        assign fwd[i] = !used[i]    ? fwd_rf :
                        alu_hit[i]  ? fwd_alu :
                        load_hit[i] ? fwd_load : fwd_rf;
        // load data still in flight so execute waits
        assign hazard[i] = used[i]
            && ((mem_ld && info.rd_memory == src_reg[i])
                || (wait_ld && info.rt_memory_wait == src_reg[i]));
    end

    assign stall_pc = |hazard;

    // bubble goes downstream while execute holds
    assign instr_output = stall_pc ? instr_nop : instr_exe;

    // operand enables and pc overrides by instruction class
    always_comb begin
        sel_a_in     = fwd[0];
        sel_b_in     = fwd[1];
        sel_shift_in = fwd[2];
        sel_shift    = 1'b0;
        en_a         = 1'b0;
        en_b         = 1'b0;
        en_s         = 1'b0;

        if (!opcode[6] && opcode[5:4] != 2'b10 && cond != 4'b1111) begin
            // normal data processing
            en_a      = opcode[3];
            en_b      = opcode[4];          // register operand
            en_s      = opcode[4];
            sel_shift = opcode[4] ? opcode[5] : 1'b0;  // reg shift vs imm shift
        end else if (is_mem(opcode)) begin
            en_a = 1'b1;                    // base always from rn
            if (!opcode[3]) begin
                if (ldr_lit)
                    sel_a_in = fwd_pc;      // pc relative literal pool
            end else begin
                en_b = 1'b1;                // register offset
                en_s = 1'b1;
            end
        end else if (is_branch(opcode)) begin
            if (!opcode[0])
                sel_a_in = fwd_pc;          // imm branch off pc
            sel_shift    = 1'b1;
            sel_shift_in = fwd_pc;
            en_b         = opcode[0];       // bx style target in rm
            en_s         = 1'b1;
        end
    end

    // the bubble sent out during a stall lands in the memory stage
    a_stall_bubble: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall_pc |=> info.opcode_memory == opcode_nop
    );

    a_pc_select: assert property (
        @(posedge clk) disable iff (!rst_n)
        sel_a_in == fwd_pc |-> (is_branch(opcode) || ldr_lit)
    );

endmodule

`default_nettype wire

// File: rtl/stage_shadow_chain.sv
`timescale 1ns/1ps
`default_nettype none

module stage_shadow_chain #(
    parameter int shadow_depth = 3   // stages after execute
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [31:0]      instr_output,  // execute output with nop during a stall
    stage_info_if.producer   info
);
    import cpu_pkg::*;

    localparam int wb_idx = shadow_depth - 1;  // last stage stands in for writeback

    logic [31:0] stage_q [shadow_depth];   // 0 memory, 1 wait, rest writeback side
    instr_u      mem_view;
    instr_u      wait_view;
    instr_u      wb_view;

    if (shadow_depth < 3) begin : g_depth_check
        $error("stage_shadow_chain needs at least memory, wait and writeback");
    end

    // shift one stage per clock and fill with nops on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < shadow_depth; i++)
                stage_q[i] <= instr_nop;
        end else begin
            stage_q[0] <= instr_output;
            for (int i = 1; i < shadow_depth; i++)
                stage_q[i] <= stage_q[i-1];
        end
    end

    assign mem_view  = stage_q[0];
    assign wait_view = stage_q[1];
    assign wb_view   = stage_q[wb_idx];

    // memory stage
    assign info.opcode_memory = decode_opcode(stage_q[0]);
    assign info.rd_memory     = mem_view.dp.rd;
    assign info.rn_memory     = mem_view.ls.rn;
    assign info.sel_w_addr1_memory =
        (is_mem(info.opcode_memory) && mem_view.ls.w) ? wsel_pre : wsel_none;

    // wait stage
    assign info.opcode_memory_wait = decode_opcode(stage_q[1]);
    assign info.rt_memory_wait     = wait_view.ls.rt;

    // writeback
    assign info.opcode_writeback = decode_opcode(stage_q[wb_idx]);
    assign info.rt_writeback     = wb_view.ls.rt;

    // pre-indexed select only for a memory word that came in with W set
    a_wsel_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        info.sel_w_addr1_memory != wsel_none
            |-> info.sel_w_addr1_memory == wsel_pre
                && is_mem(decode_opcode($past(instr_output)))
                && $past(instr_output[21])
    );

endmodule

`default_nettype wire

// File: rtl/execute_pipeline_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_pipeline_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [31:0]       instr_in,
    input  logic              branch_in,
    input  logic              sel_stall,     // level stall from controller
    output cpu_pkg::cond_t    cond,
    output cpu_pkg::opcode_t  opcode,
    output cpu_pkg::reg_idx_t rn,
    output cpu_pkg::reg_idx_t rs,
    output cpu_pkg::reg_idx_t rm,
    output logic [4:0]        imm5,
    output logic              branch_value,
    output logic [31:0]       instr_output
);
    import cpu_pkg::*;

    logic [31:0] instr_q;   // execute instruction register
    logic        branch_q;
    instr_u      view;

    // load, squash on branch, hold on stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_q  <= instr_nop;
            branch_q <= 1'b0;
        end else if (!sel_stall) begin
            instr_q  <= branch_in ? instr_nop : instr_in;  // taken branch kills the slot
            branch_q <= branch_in;
        end
    end

    assign view = instr_q;

    // field decode straight off the register
    assign cond   = view.dp.cond;
    assign opcode = decode_opcode(instr_q);
    assign rn     = view.dp.rn;
    assign rs     = view.dp.rs;
    assign rm     = view.dp.rm;
    assign imm5   = view.ls.imm5;   // shift amount / offset field

    assign branch_value = branch_q;
    assign instr_output = instr_q;

    // a stalled cycle must leave the slot untouched
    a_stall_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        sel_stall |=> (instr_q == $past(instr_q) && branch_q == $past(branch_q))
    );

endmodule

`default_nettype wire

// File: rtl/stage_info_if.sv
`timescale 1ns/1ps
`default_nettype none

interface stage_info_if;
    import cpu_pkg::*;

    // memory stage, feeds forwarding and load-use stall
    opcode_t  opcode_memory;
    reg_idx_t rd_memory;
    reg_idx_t rn_memory;          // base reg for pre-indexed writeback
    wsel_t    sel_w_addr1_memory;

    // wait stage, stall only
    opcode_t  opcode_memory_wait;
    reg_idx_t rt_memory_wait;

    // writeback stage, load forwarding
    opcode_t  opcode_writeback;
    reg_idx_t rt_writeback;

    modport producer (
        output opcode_memory, rd_memory, rn_memory, sel_w_addr1_memory,
        output opcode_memory_wait, rt_memory_wait,
        output opcode_writeback, rt_writeback
    );

    modport consumer (
        input opcode_memory, rd_memory, rn_memory, sel_w_addr1_memory,
        input opcode_memory_wait, rt_memory_wait,
        input opcode_writeback, rt_writeback
    );

endinterface

`default_nettype wire

// File: rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [6:0] opcode_t;
    typedef logic [3:0] reg_idx_t;
    typedef logic [3:0] cond_t;
    typedef logic [1:0] wsel_t;     // memory stage write address select
    typedef logic [1:0] fwd_sel_t;  // operand source select

    localparam opcode_t opcode_nop = 7'b0100000;
    localparam logic [31:0] instr_nop = 32'hE320F000;  // mov r0, r0 style hint word

    localparam wsel_t wsel_none = 2'b00;
    localparam wsel_t wsel_pre  = 2'b10;   // pre-indexed base writeback

    localparam fwd_sel_t fwd_rf   = 2'b00; // register file
    localparam fwd_sel_t fwd_alu  = 2'b01; // alu result sitting in memory stage
    localparam fwd_sel_t fwd_load = 2'b10; // load data in writeback
    localparam fwd_sel_t fwd_pc   = 2'b11;

    // data processing view of the instruction word
    typedef struct packed {
        cond_t    cond;
        logic     rsvd27;
        opcode_t  opcode;
        reg_idx_t rn;
        reg_idx_t rd;
        reg_idx_t rs;
        logic [3:0] rsvd7_4;
        reg_idx_t rm;
    } dp_view_t;

    // load/store view, W sits inside the opcode bits
    typedef struct packed {
        cond_t    cond;
        logic     rsvd27;
        logic [4:0] op_hi;  // opcode bits 26:22
        logic     w;        // base writeback
        logic     op_lo;    // opcode bit 20
        reg_idx_t rn;
        reg_idx_t rt;
        logic [4:0] imm5;
        logic [2:0] rsvd6_4;
        reg_idx_t rm;
    } ls_view_t;

    typedef union packed {
        dp_view_t dp;
        ls_view_t ls;
    } instr_u;

    // nop word maps onto the dedicated nop opcode
    function automatic opcode_t decode_opcode(input logic [31:0] word);
        instr_u w;
        w = word;
        return (word == instr_nop) ? opcode_nop : w.dp.opcode;
    endfunction

    function automatic logic uses_rn(input opcode_t op);
        return (op != opcode_nop) && ((!op[6] && op[3:0] != 4'b0000) || op[6:5] == 2'b11);
    endfunction

    function automatic logic uses_rm(input opcode_t op);
        return (!op[6] && op[4]) || (op[6:5] == 2'b11 && op[3]) || (op[6:2] == 5'b10010 && op[0]);
    endfunction

    function automatic logic uses_rs(input opcode_t op);
        return op[6:4] == 3'b011;
    endfunction

    function automatic logic is_load(input opcode_t op);
        return op[6:4] == 3'b110 || op[6:3] == 4'b1000;  // ldr or ldr_lit
    endfunction

    function automatic logic writes_rd(input opcode_t op);
        return !op[6];
    endfunction

    function automatic logic is_mem(input opcode_t op);
        return op[6:5] == 2'b11 || is_load(op);
    endfunction

    function automatic logic is_branch(input opcode_t op);
        return op[6:3] == 4'b1001;
    endfunction

endpackage

`default_nettype wire
